//--- design/glb_bank.sv
`include "glb_settings.svh"

module glb_bank import glb_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,

    // Host requester.
    input  logic                              host_wr_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]   host_wr_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   host_wr_data,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   host_wr_bit_sel,
    input  logic                              host_rd_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]   host_rd_addr,

    // Stream requester.
    input  logic                              strm_wr_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]   strm_wr_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   strm_wr_data,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   strm_wr_bit_sel,
    input  logic                              strm_rd_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]   strm_rd_addr,

    // Stream request lost to the host.
    output logic                              strm_drop,

    // Read responses.
    output logic [`GLB_BANK_DATA_WIDTH-1:0]   host_rd_data,
    output logic                              host_rd_data_valid,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]   strm_rd_data,
    output logic                              strm_rd_data_valid
);

    // ==================================================================
    // Stage links
    // ==================================================================

    glb_req_if req_if ();
    glb_mem_if mem_if ();

    // Controller to router.
    logic [`GLB_BANK_DATA_WIDTH-1:0]   rd_data;
    logic                              rd_data_valid;
    packet_sel_t                       rdrs_sel;

    // ==================================================================
    // Pipeline stages
    // ==================================================================

    // Stage 1 arbitrates with the host first.
    glb_packet_arb glb_packet_arb_inst (
        .clk             (clk),
        .reset           (reset),
        .host_wr_en      (host_wr_en),
        .host_wr_addr    (host_wr_addr),
        .host_wr_data    (host_wr_data),
        .host_wr_bit_sel (host_wr_bit_sel),
        .host_rd_en      (host_rd_en),
        .host_rd_addr    (host_rd_addr),
        .strm_wr_en      (strm_wr_en),
        .strm_wr_addr    (strm_wr_addr),
        .strm_wr_data    (strm_wr_data),
        .strm_wr_bit_sel (strm_wr_bit_sel),
        .strm_rd_en      (strm_rd_en),
        .strm_rd_addr    (strm_rd_addr),
        .strm_drop       (strm_drop),
        .req             (req_if.arb)
    );

    // Stage 2 drives the memory strobes and forms the response.
    glb_bank_ctrl glb_bank_ctrl_inst (
        .clk           (clk),
        .reset         (reset),
        .req           (req_if.ctrl),
        .mem           (mem_if.ctrl),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rdrs_sel      (rdrs_sel)
    );

    // Stage 3 holds the storage.
    glb_bank_mem glb_bank_mem_inst (
        .clk (clk),
        .mem (mem_if.mem)
    );

    // Stage 4 returns each read to its requester.
    glb_rdrs_router glb_rdrs_router_inst (
        .clk                (clk),
        .reset              (reset),
        .rd_data            (rd_data),
        .rd_data_valid      (rd_data_valid),
        .rdrs_sel           (rdrs_sel),
        .host_rd_data       (host_rd_data),
        .host_rd_data_valid (host_rd_data_valid),
        .strm_rd_data       (strm_rd_data),
        .strm_rd_data_valid (strm_rd_data_valid)
    );

endmodule

//--- design/glb_bank_ctrl.sv
`include "glb_settings.svh"

module glb_bank_ctrl import glb_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,

    // Registered request from the arbiter.
    glb_req_if.ctrl                           req,

    // Memory strobes and read data.
    glb_mem_if.ctrl                           mem,

    // Read response toward the router.
    output logic [`GLB_BANK_DATA_WIDTH-1:0]   rd_data,
    output logic                              rd_data_valid,
    output packet_sel_t                       rdrs_sel
);

    // ==================================================================
    // Local state
    // ==================================================================

    logic                              rd_en_d1;
    packet_sel_t                       rdrs_sel_d1;
    logic [`GLB_BANK_DATA_WIDTH-1:0]   rd_data_d1;

    // ==================================================================
    // Memory strobes
    // ==================================================================

    // Write first; a read in the same cycle is dropped silently.
    always_comb begin
        if (req.wr_en) begin
            mem.wr_en           = 1'b1;
            mem.rd_en           = 1'b0;
            mem.addr            = req.wr_addr;
            mem.data_in         = req.wr_data;
            mem.data_in_bit_sel = req.wr_bit_sel;
        end else if (req.rd_en) begin
            mem.wr_en           = 1'b0;
            mem.rd_en           = 1'b1;
            mem.addr            = req.rd_addr;
            mem.data_in         = '0;
            mem.data_in_bit_sel = '0;
        end else begin
            // Idle.
            mem.wr_en           = 1'b0;
            mem.rd_en           = 1'b0;
            mem.addr            = '0;
            mem.data_in         = '0;
            mem.data_in_bit_sel = '0;
        end
    end

    // ==================================================================
    // Read response
    // ==================================================================

    // Delay the issued read and its tag to line up with data_out.
    // Held data tracks what goes out so it stays put when idle.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_d1    <= 1'b0;
            rdrs_sel_d1 <= PSEL_NONE;
            rd_data_d1  <= '0;
        end else begin
            rd_en_d1    <= mem.rd_en;
            rdrs_sel_d1 <= mem.rd_en ? req.rdrq_sel : PSEL_NONE;
            rd_data_d1  <= rd_data;
        end
    end

    // Fresh word while valid, last value otherwise.
    assign rd_data       = rd_en_d1 ? mem.data_out : rd_data_d1;
    assign rd_data_valid = rd_en_d1;
    assign rdrs_sel      = rdrs_sel_d1;

endmodule

//--- design/glb_bank_if.sv
`include "glb_settings.svh"

// ======================================================================
// Request path, arbiter to bank controller
// ======================================================================

interface glb_req_if import glb_pkg::*; ();

    // Write request with per-bit mask.
    logic                              wr_en;
    logic [`GLB_BANK_ADDR_WIDTH-1:0]   wr_addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0]   wr_data;
    logic [`GLB_BANK_DATA_WIDTH-1:0]   wr_bit_sel;

    // Read request and its requester tag.
    logic                              rd_en;
    logic [`GLB_BANK_ADDR_WIDTH-1:0]   rd_addr;
    packet_sel_t                       rdrq_sel;

    modport arb (
        output wr_en, wr_addr, wr_data, wr_bit_sel,
        output rd_en, rd_addr, rdrq_sel
    );

    modport ctrl (
        input  wr_en, wr_addr, wr_data, wr_bit_sel,
        input  rd_en, rd_addr, rdrq_sel
    );

endinterface

// ======================================================================
// Memory port, bank controller to memory
// ======================================================================

interface glb_mem_if ();

    logic                              rd_en;
    logic                              wr_en;
    logic [`GLB_BANK_ADDR_WIDTH-1:0]   addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0]   data_in;
    logic [`GLB_BANK_DATA_WIDTH-1:0]   data_in_bit_sel;
    // Registered read data from the array.
    logic [`GLB_BANK_DATA_WIDTH-1:0]   data_out;

    modport ctrl (
        output rd_en, wr_en, addr, data_in, data_in_bit_sel,
        input  data_out
    );

    modport mem (
        input  rd_en, wr_en, addr, data_in, data_in_bit_sel,
        output data_out
    );

endinterface

//--- design/glb_bank_mem.sv
`include "glb_settings.svh"

module glb_bank_mem import glb_pkg::*; (
    input  logic    clk,
    glb_mem_if.mem  mem
);

    // ==================================================================
    // Storage
    // ==================================================================

    // Inferred single-port array whose contents are undefined after power-up.
    logic [`GLB_BANK_DATA_WIDTH-1:0] mem_array [`GLB_BANK_DEPTH];

    // Merge of the new data with the stored word under the mask.
    logic [`GLB_BANK_DATA_WIDTH-1:0] wr_word;

    // ==================================================================
    // Bit-select write
    // ==================================================================

    // Bits with mask one take new data; the rest keep the old word.
    assign wr_word = (mem_array[mem.addr] & ~mem.data_in_bit_sel)
                   | (mem.data_in & mem.data_in_bit_sel);

    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            mem_array[mem.addr] <= wr_word;
        end
    end

    // ==================================================================
    // Registered read
    // ==================================================================

    // One cycle latency.
    // data_out holds between reads.
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.data_out <= mem_array[mem.addr];
        end
    end

endmodule

//--- design/glb_packet_arb.sv
`include "glb_settings.svh"

module glb_packet_arb import glb_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,

    // Host requester.
    input  logic                              host_wr_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]   host_wr_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   host_wr_data,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   host_wr_bit_sel,
    input  logic                              host_rd_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]   host_rd_addr,

    // Stream requester.
    input  logic                              strm_wr_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]   strm_wr_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   strm_wr_data,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   strm_wr_bit_sel,
    input  logic                              strm_rd_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]   strm_rd_addr,

    output logic                              strm_drop,
    glb_req_if.arb                            req
);

    // ==================================================================
    // Grant decision
    // ==================================================================

    logic host_active;
    logic strm_active;

    // Any host strobe takes the bank for this cycle.
    assign host_active = host_wr_en | host_rd_en;
    assign strm_active = strm_wr_en | strm_rd_en;

    // ==================================================================
    // Registered strobes, tag and drop pulse
    // ==================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req.wr_en    <= 1'b0;
            req.rd_en    <= 1'b0;
            req.rdrq_sel <= PSEL_NONE;
            strm_drop    <= 1'b0;
        end else begin
            if (host_active) begin
                req.wr_en    <= host_wr_en;
                req.rd_en    <= host_rd_en;
                req.rdrq_sel <= host_rd_en ? PSEL_HOST : PSEL_NONE;
            end else begin
                req.wr_en    <= strm_wr_en;
                req.rd_en    <= strm_rd_en;
                req.rdrq_sel <= strm_rd_en ? PSEL_STRM : PSEL_NONE;
            end
            // Stream that lost to the host gets a one-cycle notice.
            strm_drop <= host_active & strm_active;
        end
    end

    // Payload follows the same grant; only qualified by the strobes.
    always_ff @(posedge clk) begin
        if (host_active) begin
            req.wr_addr    <= host_wr_addr;
            req.wr_data    <= host_wr_data;
            req.wr_bit_sel <= host_wr_bit_sel;
            req.rd_addr    <= host_rd_addr;
        end else begin
            req.wr_addr    <= strm_wr_addr;
            req.wr_data    <= strm_wr_data;
            req.wr_bit_sel <= strm_wr_bit_sel;
            req.rd_addr    <= strm_rd_addr;
        end
    end

endmodule

//--- design/glb_pkg.sv
// ======================================================================
// Shared types for the global buffer bank
// ======================================================================

package glb_pkg;

    // Tag that travels with a read request.
    // It names the requester that gets the read response.
    // PSEL_NONE marks a cycle with no read in flight.
    typedef enum logic [1:0] {
        PSEL_NONE = 2'd0,
        PSEL_HOST = 2'd1,
        PSEL_STRM = 2'd2
    } packet_sel_t;

endpackage

//--- design/glb_rdrs_router.sv
`include "glb_settings.svh"

module glb_rdrs_router import glb_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,

    // Response from the bank controller.
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   rd_data,
    input  logic                              rd_data_valid,
    input  packet_sel_t                       rdrs_sel,

    // Host side.
    output logic [`GLB_BANK_DATA_WIDTH-1:0]   host_rd_data,
    output logic                              host_rd_data_valid,

    // Stream side.
    output logic [`GLB_BANK_DATA_WIDTH-1:0]   strm_rd_data,
    output logic                              strm_rd_data_valid
);

    logic host_hit;
    logic strm_hit;

    // Valid response addressed to each side.
    assign host_hit = rd_data_valid && (rdrs_sel == PSEL_HOST);
    assign strm_hit = rd_data_valid && (rdrs_sel == PSEL_STRM);

    // ==================================================================
    // Output registers
    // ==================================================================

    // Valid is a one-cycle pulse; data keeps the last delivered word.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            host_rd_data_valid <= 1'b0;
            strm_rd_data_valid <= 1'b0;
            host_rd_data       <= '0;
            strm_rd_data       <= '0;
        end else begin
            host_rd_data_valid <= host_hit;
            strm_rd_data_valid <= strm_hit;
            if (host_hit) begin
                host_rd_data <= rd_data;
            end
            if (strm_hit) begin
                strm_rd_data <= rd_data;
            end
        end
    end

endmodule

//--- design/glb_settings.svh
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// ======================================================================
// Bank geometry
// ======================================================================

// Word address width for 256 words per bank.
`define GLB_BANK_ADDR_WIDTH 8

// Word width in bits.
`define GLB_BANK_DATA_WIDTH 32

// Number of words follows from the address width.
`define GLB_BANK_DEPTH (1 << `GLB_BANK_ADDR_WIDTH)

`endif

//--- sim/glb_bank_tb.sv
`include "glb_settings.svh"

module glb_bank_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FILL_CYCLES = `GLB_BANK_DEPTH;
    localparam int RAND_CYCLES = 2000;
    localparam int CYCLE_LIMIT = FILL_CYCLES + RAND_CYCLES + 20;

    logic clk;
    logic reset;
    logic host_wr_en, host_rd_en, strm_wr_en, strm_rd_en;
    logic [`GLB_BANK_ADDR_WIDTH-1:0] host_wr_addr, host_rd_addr, strm_wr_addr, strm_rd_addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0] host_wr_data, host_wr_bit_sel;
    logic [`GLB_BANK_DATA_WIDTH-1:0] strm_wr_data, strm_wr_bit_sel;
    logic strm_drop, host_rd_data_valid, strm_rd_data_valid;
    logic [`GLB_BANK_DATA_WIDTH-1:0] host_rd_data, strm_rd_data;

    // Reference model with a memory image plus a three-stage response pipe.
    logic [`GLB_BANK_DATA_WIDTH-1:0] model_mem [`GLB_BANK_DEPTH];
    logic                            pipe_host_v [3];
    logic                            pipe_strm_v [3];
    logic [`GLB_BANK_DATA_WIDTH-1:0] pipe_data [3];
    logic [`GLB_BANK_DATA_WIDTH-1:0] exp_host_data, exp_strm_data;
    logic                            exp_drop;
    logic [31:0]                     lfsr = 32'h590f;
    int                              error_count = 0;
    int                              cycle_count = 0;

    glb_clk_gen glb_clk_gen_inst (.clk(clk), .reset(reset));

    glb_bank glb_bank_inst (.*);

    // ======================================================================
    // Random source
    // ======================================================================

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // One step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Half the addresses fall in a small window, so hits on recent writes are common.
    function automatic logic [`GLB_BANK_ADDR_WIDTH-1:0] pick_addr();
        if (rand_bits(1)) return rand_bits(3);
        return rand_bits(`GLB_BANK_ADDR_WIDTH);
    endfunction

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic expect_pulse(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            if (exp) $display("Missing %s pulse at %0t", name, $time);
            else $display("Unexpected %s pulse at %0t", name, $time);
        end
    endtask

    task automatic compare_word(input string name,
                                input logic [`GLB_BANK_DATA_WIDTH-1:0] exp,
                                input logic [`GLB_BANK_DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            error_count++;
            $display("error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    // Oldest pipe entry is due this cycle; data outputs hold otherwise.
    task automatic check_outputs();
        if (pipe_host_v[2]) exp_host_data = pipe_data[2];
        if (pipe_strm_v[2]) exp_strm_data = pipe_data[2];
        expect_pulse("strm_drop", exp_drop, strm_drop);
        expect_pulse("host_rd_data_valid", pipe_host_v[2], host_rd_data_valid);
        expect_pulse("strm_rd_data_valid", pipe_strm_v[2], strm_rd_data_valid);
        compare_word("host_rd_data", exp_host_data, host_rd_data);
        compare_word("strm_rd_data", exp_strm_data, strm_rd_data);
    endtask

    // ======================================================================
    // Stimulus and model update
    // ======================================================================

    // Mode 0 idle, 1 full-mask host fill at addr, 2 random traffic.
    task automatic run_cycle(input int mode, input int addr);
        logic                            h_act, s_act, g_wr, g_rd;
        logic [`GLB_BANK_ADDR_WIDTH-1:0] waddr, raddr;
        logic [`GLB_BANK_DATA_WIDTH-1:0] wdata, wmask;
        check_outputs();
        for (int i = 2; i > 0; i--) begin
            pipe_host_v[i] = pipe_host_v[i-1];
            pipe_strm_v[i] = pipe_strm_v[i-1];
            pipe_data[i]   = pipe_data[i-1];
        end
        // Each strobe is set one time in four.
        host_wr_en      = (mode == 2) ? (rand_bits(2) == 0) : (mode == 1);
        host_rd_en      = (mode == 2) ? (rand_bits(2) == 0) : 1'b0;
        strm_wr_en      = (mode == 2) ? (rand_bits(2) == 0) : 1'b0;
        strm_rd_en      = (mode == 2) ? (rand_bits(2) == 0) : 1'b0;
        host_wr_addr    = (mode == 1) ? addr : pick_addr();
        host_rd_addr    = pick_addr();
        strm_wr_addr    = pick_addr();
        strm_rd_addr    = pick_addr();
        host_wr_data    = rand_bits(32);
        strm_wr_data    = rand_bits(32);
        host_wr_bit_sel = (mode == 1) ? '1 : rand_bits(32);
        strm_wr_bit_sel = rand_bits(32);
        // Host wins the bank whenever it has any strobe.
        h_act    = host_wr_en | host_rd_en;
        s_act    = strm_wr_en | strm_rd_en;
        exp_drop = h_act & s_act;
        g_wr     = h_act ? host_wr_en : strm_wr_en;
        g_rd     = h_act ? host_rd_en : strm_rd_en;
        waddr    = h_act ? host_wr_addr : strm_wr_addr;
        raddr    = h_act ? host_rd_addr : strm_rd_addr;
        wdata    = h_act ? host_wr_data : strm_wr_data;
        wmask    = h_act ? host_wr_bit_sel : strm_wr_bit_sel;
        pipe_host_v[0] = 1'b0;
        pipe_strm_v[0] = 1'b0;
        pipe_data[0]   = '0;
        // Write beats read; the read then gets no response.
        if (g_wr) begin
            // Only the bits selected by the mask take the new data.
            for (int b = 0; b < `GLB_BANK_DATA_WIDTH; b++) begin
                if (wmask[b]) model_mem[waddr][b] = wdata[b];
            end
        end else if (g_rd) begin
            pipe_data[0]   = model_mem[raddr];
            pipe_host_v[0] = h_act;
            pipe_strm_v[0] = ~h_act;
        end
        @(posedge clk);
        #10;
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        {host_wr_en, host_rd_en, strm_wr_en, strm_rd_en} = '0;
        {host_wr_addr, host_rd_addr, strm_wr_addr, strm_rd_addr} = '0;
        {host_wr_data, host_wr_bit_sel, strm_wr_data, strm_wr_bit_sel} = '0;
        for (int i = 0; i < 3; i++) begin
            pipe_host_v[i] = 1'b0;
            pipe_strm_v[i] = 1'b0;
            pipe_data[i]   = '0;
        end
        exp_host_data = '0;
        exp_strm_data = '0;
        exp_drop      = 1'b0;
        // Pulses must stay low while reset is held.
        forever begin
            @(posedge clk);
            #10;
            if (!reset) break;
            if (host_rd_data_valid !== 1'b0 || strm_rd_data_valid !== 1'b0
                    || strm_drop !== 1'b0) begin
                error_count++;
                $display("Valid or drop output not low during reset at %0t", $time);
            end
        end
        for (int a = 0; a < FILL_CYCLES; a++) run_cycle(1, a);
        for (int n = 0; n < RAND_CYCLES; n++) run_cycle(2, 0);
        // Drain the responses still in flight.
        repeat (4) run_cycle(0, 0);
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Stops a stuck run.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, errors so far: %0d", cycle_count, error_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

//--- sim/glb_clk_gen.sv
module glb_clk_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over the first four rising edges.
    // Released on the fourth edge itself.
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- src.f
+incdir+design
design/glb_pkg.sv
design/glb_bank_if.sv
design/glb_packet_arb.sv
design/glb_bank_ctrl.sv
design/glb_bank_mem.sv
design/glb_rdrs_router.sv
design/glb_bank.sv
sim/glb_clk_gen.sv
sim/glb_bank_tb.sv
